// ==== compile.f ====
rtl/ddma_pkg.sv
rtl/node_memory.sv
rtl/dma_bus_arbiter.sv
rtl/dma_send_engine.sv
rtl/dma_recv_engine.sv
rtl/ddma_node.sv
tb/tb_clock_gen.sv
tb/tb_ddma_node.sv

// ==== rtl/ddma_node.sv ====
`timescale 1ns/1ps

module ddma_node import ddma_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     i_cfg_valid,
  input  logic [ADDR_WIDTH-1:0]    i_cfg_addr,
  input  logic [COUNT_WIDTH-1:0]   i_cfg_count,
  output logic                     o_cfg_ready,
  output logic                     o_tx_valid,
  output logic [FLIT_WIDTH-1:0]    o_tx_flit,
  input  logic                     i_tx_ready,
  input  logic                     i_rx_valid,
  input  logic [FLIT_WIDTH-1:0]    i_rx_flit,
  output logic                     o_rx_ready,
  output logic                     o_irq,
  output logic [NODE_ID_WIDTH-1:0] o_rx_src,
  output logic [COUNT_WIDTH-1:0]   o_rx_len
);

  logic                  send_req;
  logic                  send_grant;
  logic [ADDR_WIDTH-1:0] send_addr;
  logic                  recv_req;
  logic                  recv_grant;
  logic [ADDR_WIDTH-1:0] recv_addr;
  logic                  recv_wr;
  logic [FLIT_WIDTH-1:0] recv_data;
  logic [ADDR_WIDTH-1:0] mem_addr;
  logic                  mem_wr;
  logic [FLIT_WIDTH-1:0] mem_wdata;
  logic [FLIT_WIDTH-1:0] mem_rdata;

  dma_send_engine u_send (
    .clock       (clock),
    .reset       (reset),
    .i_cfg_valid (i_cfg_valid),
    .i_cfg_addr  (i_cfg_addr),
    .i_cfg_count (i_cfg_count),
    .o_cfg_ready (o_cfg_ready),
    .o_req       (send_req),
    .o_addr      (send_addr),
    .i_grant     (send_grant),
    .i_mem_rdata (mem_rdata),
    .o_tx_valid  (o_tx_valid),
    .o_tx_flit   (o_tx_flit),
    .i_tx_ready  (i_tx_ready)
  );

  dma_recv_engine u_recv (
    .clock      (clock),
    .reset      (reset),
    .o_req      (recv_req),
    .i_grant    (recv_grant),
    .o_addr     (recv_addr),
    .o_wr       (recv_wr),
    .o_data     (recv_data),
    .i_rx_valid (i_rx_valid),
    .i_rx_flit  (i_rx_flit),
    .o_rx_ready (o_rx_ready),
    .o_irq      (o_irq),
    .o_rx_src   (o_rx_src),
    .o_rx_len   (o_rx_len)
  );

  dma_bus_arbiter u_arbiter (
    .clock        (clock),
    .reset        (reset),
    .i_send_req   (send_req),
    .i_recv_req   (recv_req),
    .i_send_addr  (send_addr),
    .i_recv_addr  (recv_addr),
    .i_recv_wr    (recv_wr),
    .i_recv_data  (recv_data),
    .o_send_grant (send_grant),
    .o_recv_grant (recv_grant),
    .o_mem_addr   (mem_addr),
    .o_mem_wr     (mem_wr),
    .o_mem_data   (mem_wdata)
  );

  node_memory u_memory (
    .clock   (clock),
    .i_addr  (mem_addr),
    .i_wr    (mem_wr),
    .i_wdata (mem_wdata),
    .o_rdata (mem_rdata)
  );

endmodule

// ==== rtl/ddma_pkg.sv ====
package ddma_pkg;

  // memory word and flit share one width
  localparam int FLIT_WIDTH = 32;
  localparam int ADDR_WIDTH = 11;
  localparam int MEM_DEPTH = 2048;
  localparam int COUNT_WIDTH = 10;
  localparam int NODE_ID_WIDTH = 16;

  // receive buffer holds header, size and then payload words
  localparam int RECV_BASE = 1024;
  localparam int RECV_SIZE = 512;
  localparam int RECV_END = RECV_BASE + RECV_SIZE;
  localparam int RECV_MAX_LEN = RECV_SIZE - 2;

  // bus interleaving
  localparam int INTERLEAVE_GRAIN = 3;
  localparam int GRAIN_WIDTH = $clog2(INTERLEAVE_GRAIN + 1);
  localparam logic TOKEN_SEND = 1'b0;
  localparam logic TOKEN_RECV = 1'b1;

  // receive FSM encoding
  localparam logic [2:0] RX_IDLE = 3'd0;
  localparam logic [2:0] RX_HEADER = 3'd1;
  localparam logic [2:0] RX_SIZE = 3'd2;
  localparam logic [2:0] RX_PAYLOAD = 3'd3;
  localparam logic [2:0] RX_IRQ = 3'd4;

  // a flit seen either as a plain word or as a packet header
  typedef union packed {
    logic [FLIT_WIDTH-1:0] raw;
    struct packed {
      logic [NODE_ID_WIDTH-1:0] src;
      logic [NODE_ID_WIDTH-1:0] dst;
    } hdr;
  } ddma_flit_u;

endpackage

// ==== rtl/dma_bus_arbiter.sv ====
`timescale 1ns/1ps

module dma_bus_arbiter import ddma_pkg::*; (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  i_send_req,
  input  logic                  i_recv_req,
  input  logic [ADDR_WIDTH-1:0] i_send_addr,
  input  logic [ADDR_WIDTH-1:0] i_recv_addr,
  input  logic                  i_recv_wr,
  input  logic [FLIT_WIDTH-1:0] i_recv_data,
  output logic                  o_send_grant,
  output logic                  o_recv_grant,
  output logic [ADDR_WIDTH-1:0] o_mem_addr,
  output logic                  o_mem_wr,
  output logic [FLIT_WIDTH-1:0] o_mem_data
);

  logic                   token;
  logic [GRAIN_WIDTH-1:0] grain_cnt;
  logic                   holder_req;
  logic                   other_req;

  assign holder_req = (token == TOKEN_RECV) ? i_recv_req : i_send_req;
  assign other_req  = (token == TOKEN_RECV) ? i_send_req : i_recv_req;

  // the token holder owns the bus only while it asks for it
  assign o_send_grant = (token == TOKEN_SEND) && i_send_req;
  assign o_recv_grant = (token == TOKEN_RECV) && i_recv_req;

  always_ff @(posedge clock) begin
    if (!reset) begin
      token     <= TOKEN_SEND;
      grain_cnt <= GRAIN_WIDTH'(INTERLEAVE_GRAIN);
    end else if (other_req && !holder_req) begin
      // idle holder gives way at once
      token     <= ~token;
      grain_cnt <= GRAIN_WIDTH'(INTERLEAVE_GRAIN);
    end else if (other_req) begin
      if (grain_cnt == GRAIN_WIDTH'(1)) begin
        token     <= ~token;
        grain_cnt <= GRAIN_WIDTH'(INTERLEAVE_GRAIN);
      end else begin
        grain_cnt <= grain_cnt - GRAIN_WIDTH'(1);
      end
    end else begin
      // without contention the grain starts over
      grain_cnt <= GRAIN_WIDTH'(INTERLEAVE_GRAIN);
    end
  end

  // only the receive side ever writes
  assign o_mem_addr = o_recv_grant ? i_recv_addr : i_send_addr;
  assign o_mem_wr   = o_recv_grant && i_recv_wr;
  assign o_mem_data = i_recv_data;

  // a waiting engine gets the bus within one grain
  a_send_wait: assert property (@(posedge clock) disable iff (!reset)
    i_send_req && !o_send_grant |-> ##[1:INTERLEAVE_GRAIN] o_send_grant);

  a_recv_wait: assert property (@(posedge clock) disable iff (!reset)
    i_recv_req && !o_recv_grant |-> ##[1:INTERLEAVE_GRAIN] o_recv_grant);

endmodule

// ==== rtl/dma_recv_engine.sv ====
`timescale 1ns/1ps

module dma_recv_engine import ddma_pkg::*; (
  input  logic                     clock,
  input  logic                     reset,
  output logic                     o_req,
  input  logic                     i_grant,
  output logic [ADDR_WIDTH-1:0]    o_addr,
  output logic                     o_wr,
  output logic [FLIT_WIDTH-1:0]    o_data,
  input  logic                     i_rx_valid,
  input  logic [FLIT_WIDTH-1:0]    i_rx_flit,
  output logic                     o_rx_ready,
  output logic                     o_irq,
  output logic [NODE_ID_WIDTH-1:0] o_rx_src,
  output logic [COUNT_WIDTH-1:0]   o_rx_len
);

  logic [2:0]            state;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [FLIT_WIDTH-1:0] rx_left;
  logic [FLIT_WIDTH-1:0] size_clamp;
  logic                  take;
  logic                  in_buf;
  ddma_flit_u            rx_word;

  assign rx_word = i_rx_flit;

  // bus is wanted for the whole header, size and payload run
  assign o_req      = (state == RX_HEADER) || (state == RX_SIZE) || (state == RX_PAYLOAD);
  assign o_rx_ready = o_req && i_grant;
  assign take       = o_rx_ready && i_rx_valid;
  assign o_irq      = (state == RX_IRQ);

  assign size_clamp = (rx_word.raw > FLIT_WIDTH'(RECV_MAX_LEN)) ?
                      FLIT_WIDTH'(RECV_MAX_LEN) : rx_word.raw;
  assign in_buf     = (wr_addr < ADDR_WIDTH'(RECV_END));

  // overflow payload is still taken from the router but not stored
  assign o_addr = wr_addr;
  assign o_wr   = take && ((state != RX_PAYLOAD) || in_buf);
  assign o_data = (state == RX_SIZE) ? size_clamp : rx_word.raw;

  always_ff @(posedge clock) begin
    if (!reset) begin
      state    <= RX_IDLE;
      wr_addr  <= ADDR_WIDTH'(RECV_BASE);
      rx_left  <= '0;
      o_rx_src <= '0;
      o_rx_len <= '0;
    end else begin
      if (o_wr) begin
        wr_addr <= wr_addr + ADDR_WIDTH'(1);
      end
      case (state)
        RX_IDLE: begin
          wr_addr <= ADDR_WIDTH'(RECV_BASE);
          if (i_rx_valid) begin
            state <= RX_HEADER;
          end
        end
        RX_HEADER: begin
          if (take) begin
            o_rx_src <= rx_word.hdr.src;
            state    <= RX_SIZE;
          end
        end
        RX_SIZE: begin
          if (take) begin
            rx_left  <= rx_word.raw;
            o_rx_len <= size_clamp[COUNT_WIDTH-1:0];
            state    <= (rx_word.raw == '0) ? RX_IRQ : RX_PAYLOAD;
          end
        end
        RX_PAYLOAD: begin
          if (take) begin
            rx_left <= rx_left - FLIT_WIDTH'(1);
            if (rx_left == FLIT_WIDTH'(1)) begin
              state <= RX_IRQ;
            end
          end
        end
        default: begin
          // one cycle of interrupt before waiting for the next packet
          state <= RX_IDLE;
        end
      endcase
    end
  end

  a_wr_in_buffer: assert property (@(posedge clock) disable iff (!reset)
    o_wr |-> (o_addr >= ADDR_WIDTH'(RECV_BASE)) && (o_addr < ADDR_WIDTH'(RECV_END)));

endmodule

// ==== rtl/dma_send_engine.sv ====
`timescale 1ns/1ps

module dma_send_engine import ddma_pkg::*; (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   i_cfg_valid,
  input  logic [ADDR_WIDTH-1:0]  i_cfg_addr,
  input  logic [COUNT_WIDTH-1:0] i_cfg_count,
  output logic                   o_cfg_ready,
  output logic                   o_req,
  output logic [ADDR_WIDTH-1:0]  o_addr,
  input  logic                   i_grant,
  input  logic [FLIT_WIDTH-1:0]  i_mem_rdata,
  output logic                   o_tx_valid,
  output logic [FLIT_WIDTH-1:0]  o_tx_flit,
  input  logic                   i_tx_ready
);

  logic                   busy;
  logic                   rd_pend;
  logic [ADDR_WIDTH-1:0]  rd_addr;
  logic [COUNT_WIDTH-1:0] rd_left;
  logic                   rd_issue;
  logic                   tx_take;
  logic                   done;

  assign o_cfg_ready = !busy;
  assign o_addr      = rd_addr;

  // at most one flit in flight and no read while data is pending
  assign o_req    = busy && (rd_left != '0) && !rd_pend && !o_tx_valid;
  assign rd_issue = o_req && i_grant;
  assign tx_take  = o_tx_valid && i_tx_ready;
  assign done     = busy && (rd_left == '0) && !rd_pend && !o_tx_valid;

  always_ff @(posedge clock) begin
    if (!reset) begin
      busy       <= 1'b0;
      rd_pend    <= 1'b0;
      rd_addr    <= '0;
      rd_left    <= '0;
      o_tx_valid <= 1'b0;
    end else begin
      if (i_cfg_valid && o_cfg_ready) begin
        busy    <= 1'b1;
        rd_addr <= i_cfg_addr;
        rd_left <= i_cfg_count;
      end else if (done) begin
        busy <= 1'b0;
      end
      if (rd_issue) begin
        rd_addr <= rd_addr + ADDR_WIDTH'(1);
        rd_left <= rd_left - COUNT_WIDTH'(1);
      end
      // memory answers one cycle after the read
      rd_pend <= rd_issue;
      if (rd_pend) begin
        o_tx_valid <= 1'b1;
      end else if (tx_take) begin
        o_tx_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_pend) begin
      o_tx_flit <= i_mem_rdata;
    end
  end

  a_tx_stable: assert property (@(posedge clock) disable iff (!reset)
    o_tx_valid && !i_tx_ready |=> o_tx_valid && $stable(o_tx_flit));

endmodule

// ==== rtl/node_memory.sv ====
`timescale 1ns/1ps

module node_memory import ddma_pkg::*; (
  input  logic                  clock,
  input  logic [ADDR_WIDTH-1:0] i_addr,
  input  logic                  i_wr,
  input  logic [FLIT_WIDTH-1:0] i_wdata,
  output logic [FLIT_WIDTH-1:0] o_rdata
);

  logic [FLIT_WIDTH-1:0] mem [MEM_DEPTH];

  always_ff @(posedge clock) begin
    if (i_wr) begin
      mem[i_addr] <= i_wdata;
    end
  end

  // registered read returns old data on a same-address write
  always_ff @(posedge clock) begin
    o_rdata <= mem[i_addr];
  end

endmodule

// ==== tb/ddma_patterns.txt ====
# name mode src dst len pseed addr count stall exp_len
# mode 0 receive then send, 1 send runs while the packet arrives, 2 send only
# src, dst, pseed and addr in hex; len, count, stall (percent) and exp_len in decimal
oversize_packet  0 0a0b 0c0d 600 5a5a0001 400 512 10 510
receive_basic    0 1234 5678  16 3c3c0002 400  18  0  16
empty_packet     0 00aa 00bb   0 00000000 400   2  0   0
back_pressure    0 2222 0001  40 13572468 400  42 50  40
tail_while_recv  1 3333 0002  24 24682468 52c 100 25  24
deep_while_recv  1 4444 0003  60 0f0f7001 4c8 150 40  60
zero_count_send  2 0000 0000   0 00000000 400   0  0   0

// ==== tb/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clock,
  output logic reset
);

  // 8 ns period
  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // active low for 10 cycles and released on a falling edge
  initial begin
    reset = 1'b0;
    repeat (10) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

// ==== tb/tb_ddma_node.sv ====
`timescale 1ns/1ps

module tb_ddma_node import ddma_pkg::*; ();

  logic                     clock;
  logic                     reset;
  logic                     i_cfg_valid;
  logic [ADDR_WIDTH-1:0]    i_cfg_addr;
  logic [COUNT_WIDTH-1:0]   i_cfg_count;
  logic                     o_cfg_ready;
  logic                     o_tx_valid;
  logic [FLIT_WIDTH-1:0]    o_tx_flit;
  logic                     i_tx_ready;
  logic                     i_rx_valid;
  logic [FLIT_WIDTH-1:0]    i_rx_flit;
  logic                     o_rx_ready;
  logic                     o_irq;
  logic [NODE_ID_WIDTH-1:0] o_rx_src;
  logic [COUNT_WIDTH-1:0]   o_rx_len;

  // router queues and the pending send command shared with the driver
  ddma_flit_u               rx_q[$];
  ddma_flit_u               tx_got[$];
  ddma_flit_u               exp_q[$];
  logic [FLIT_WIDTH-1:0]    buf_model [RECV_SIZE];
  bit                       cfg_pend;
  int                       cfg_addr_r;
  int                       cfg_cnt_r;
  int                       stall_pct;
  int                       irq_cnt;
  bit                       send_idle;
  int                       cur_errs;
  int                       n_pass;
  int                       n_fail;
  int                       wd_cycles;

  string                    t_name[$];
  int                       t_mode[$];
  logic [NODE_ID_WIDTH-1:0] t_src[$];
  logic [NODE_ID_WIDTH-1:0] t_dst[$];
  int                       t_len[$];
  logic [FLIT_WIDTH-1:0]    t_pseed[$];
  int                       t_addr[$];
  int                       t_count[$];
  int                       t_stall[$];
  int                       t_exp_len[$];

  tb_clock_gen u_clock_gen (.clock(clock), .reset(reset));

  ddma_node UUT (
    .clock(clock), .reset(reset),
    .i_cfg_valid(i_cfg_valid), .i_cfg_addr(i_cfg_addr), .i_cfg_count(i_cfg_count),
    .o_cfg_ready(o_cfg_ready),
    .o_tx_valid(o_tx_valid), .o_tx_flit(o_tx_flit), .i_tx_ready(i_tx_ready),
    .i_rx_valid(i_rx_valid), .i_rx_flit(i_rx_flit), .o_rx_ready(o_rx_ready),
    .o_irq(o_irq), .o_rx_src(o_rx_src), .o_rx_len(o_rx_len)
  );

  task automatic check_flit(input string name, input int idx,
                            input ddma_flit_u exp, input ddma_flit_u act);
    if (act.raw !== exp.raw) begin
      $display("** Error %s: flit %0d expected %h actual %h", name, idx, exp.raw, act.raw);
      cur_errs++;
    end
  endtask

  task automatic check_src(input string name, input logic [NODE_ID_WIDTH-1:0] exp,
                           input logic [NODE_ID_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("** Error %s: source expected %h actual %h", name, exp, act);
      cur_errs++;
    end
  endtask

  task automatic check_len(input string name, input logic [COUNT_WIDTH-1:0] exp,
                           input logic [COUNT_WIDTH-1:0] act);
    if (act !== exp) begin
      $display("** Error %s: length expected %0d actual %0d", name, exp, act);
      cur_errs++;
    end
  endtask

  task automatic check_count(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("** Error %s: %s expected %0d actual %0d", name, what, exp, act);
      cur_errs++;
    end
  endtask

  // all DUT inputs change on the falling edge only
  always @(negedge clock) begin
    send_idle  = !cfg_pend && o_cfg_ready;
    i_tx_ready = ($urandom_range(99) >= stall_pct);
    if (o_tx_valid && i_tx_ready) begin
      tx_got.push_back(o_tx_flit);
    end
    if (o_irq) begin
      irq_cnt++;
    end
    i_cfg_valid = cfg_pend;
    i_cfg_addr  = ADDR_WIDTH'(cfg_addr_r);
    i_cfg_count = COUNT_WIDTH'(cfg_cnt_r);
    if (cfg_pend && o_cfg_ready) begin
      cfg_pend = 1'b0;
    end
    if (rx_q.size() != 0) begin
      i_rx_valid = 1'b1;
      i_rx_flit  = rx_q[0].raw;
      if (o_rx_ready) begin
        void'(rx_q.pop_front());
      end
    end else begin
      i_rx_valid = 1'b0;
      i_rx_flit  = '0;
    end
  end

  task automatic read_patterns();
    int fd, mode, len, addr, count, stall, exp_len;
    int flits;
    logic [NODE_ID_WIDTH-1:0] src, dst;
    logic [FLIT_WIDTH-1:0] pseed;
    string line, name;
    flits = 0;
    fd = $fopen("tb/ddma_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open the pattern file tb/ddma_patterns.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && line.len() > 1 && line.getc(0) != "#") begin
          if ($sscanf(line, "%s %d %h %h %d %h %h %d %d %d", name, mode, src, dst,
                      len, pseed, addr, count, stall, exp_len) == 10) begin
            t_name.push_back(name);
            t_mode.push_back(mode);
            t_src.push_back(src);
            t_dst.push_back(dst);
            t_len.push_back(len);
            t_pseed.push_back(pseed);
            t_addr.push_back(addr);
            t_count.push_back(count);
            t_stall.push_back(stall);
            t_exp_len.push_back(exp_len);
            flits += len + 2 + count + exp_len + 2;
          end
        end
      end
      $fclose(fd);
      if (t_name.size() == 0) begin
        $display("the pattern file holds no test records");
        n_fail++;
      end
    end
    wd_cycles = flits * 8 + 1000;
  endtask

  // queue the packet for the router and update the buffer model
  task automatic load_packet(input int k);
    ddma_flit_u f;
    int stored;
    int i;
    f.hdr.src = t_src[k];
    f.hdr.dst = t_dst[k];
    rx_q.push_back(f);
    buf_model[0] = f.raw;
    f.raw = FLIT_WIDTH'(t_len[k]);
    rx_q.push_back(f);
    // only the recorded length is kept behind header and size
    stored = t_exp_len[k];
    buf_model[1] = FLIT_WIDTH'(stored);
    for (i = 0; i < t_len[k]; i++) begin
      f.raw = $urandom() ^ t_pseed[k];
      rx_q.push_back(f);
      if (i < stored) begin
        buf_model[2 + i] = f.raw;
      end
    end
  endtask

  task automatic expect_send(input int addr, input int count);
    int i;
    exp_q.delete();
    for (i = 0; i < count; i++) begin
      exp_q.push_back(buf_model[addr - RECV_BASE + i]);
    end
  endtask

  task automatic start_send(input int addr, input int count);
    tx_got.delete();
    cfg_addr_r = addr;
    cfg_cnt_r  = count;
    cfg_pend   = 1'b1;
  endtask

  // o_cfg_ready back high ends a send and the interrupt ends a packet
  task automatic wait_done(input bit want_rx);
    @(posedge clock);
    while (!send_idle || (want_rx && (rx_q.size() != 0 || irq_cnt == 0))) begin
      @(posedge clock);
    end
  endtask

  task automatic compare_sent(input string name);
    int i;
    check_count(name, "flits taken", exp_q.size(), tx_got.size());
    for (i = 0; i < exp_q.size() && i < tx_got.size(); i++) begin
      check_flit(name, i, exp_q[i], tx_got[i]);
    end
  endtask

  task automatic report_test(input string name);
    if (cur_errs == 0) begin
      n_pass++;
      $display("test %s ok", name);
    end else begin
      n_fail++;
      $display("test %s FAILED with %0d mismatches", name, cur_errs);
    end
  endtask

  task automatic run_test(input int k);
    int addr;
    int count;
    cur_errs  = 0;
    irq_cnt   = 0;
    stall_pct = t_stall[k];
    addr      = t_addr[k];
    count     = t_count[k];
    if (t_mode[k] == 1) begin
      // send from another part of the buffer while the packet comes in
      expect_send(addr, count);
      start_send(addr, count);
      @(posedge clock);
      while (cfg_pend) begin
        @(posedge clock);
      end
      load_packet(k);
      wait_done(1'b1);
      compare_sent(t_name[k]);
      addr  = RECV_BASE;
      count = t_exp_len[k] + 2;
    end else if (t_mode[k] == 0) begin
      load_packet(k);
      wait_done(1'b1);
    end
    // loopback of the stored packet or the plain send
    expect_send(addr, count);
    start_send(addr, count);
    wait_done(1'b0);
    compare_sent(t_name[k]);
    if (t_mode[k] != 2) begin
      check_src(t_name[k], t_src[k], o_rx_src);
      check_len(t_name[k], COUNT_WIDTH'(t_exp_len[k]), o_rx_len);
    end
    check_count(t_name[k], "interrupts", (t_mode[k] == 2) ? 0 : 1, irq_cnt);
    report_test(t_name[k]);
  endtask

  initial begin
    i_cfg_valid = 1'b0;
    i_cfg_addr  = '0;
    i_cfg_count = '0;
    i_tx_ready  = 1'b0;
    i_rx_valid  = 1'b0;
    i_rx_flit   = '0;
    cfg_pend    = 1'b0;
    cfg_addr_r  = 0;
    cfg_cnt_r   = 0;
    stall_pct   = 0;
    irq_cnt     = 0;
    send_idle   = 1'b0;
    n_pass      = 0;
    n_fail      = 0;
    wd_cycles   = 0;
    void'($urandom(32'h5815_bad4));
    read_patterns();
    wait (reset === 1'b1);
    @(negedge clock);
    cur_errs = 0;
    check_count("reset_state", "o_tx_valid", 0, o_tx_valid);
    check_count("reset_state", "o_rx_ready", 0, o_rx_ready);
    check_count("reset_state", "o_irq", 0, o_irq);
    check_count("reset_state", "o_cfg_ready", 1, o_cfg_ready);
    check_src("reset_state", '0, o_rx_src);
    check_len("reset_state", '0, o_rx_len);
    report_test("reset_state");
    for (int k = 0; k < t_name.size(); k++) begin
      run_test(k);
    end
    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  initial begin
    wait (wd_cycles > 0);
    repeat (wd_cycles) @(posedge clock);
    $display("watchdog: the run timed out after %0d cycles and never finished", wd_cycles);
    $display("Regression failed");
    $finish;
  end

endmodule
